// File: rtl/coreBottomPkg.sv
`default_nettype none

package coreBottomPkg;

	localparam int rstBaseW = 16;	// Restart base width

	// Register transfer operations
	typedef enum logic [2:0] {
		opLoadImm  = 3'd0,	// Reg from immediate
		opCopy     = 3'd1,	// Reg from reg
		opIncPair  = 3'd2,	// Pair plus one
		opDecPair  = 3'd3,	// Pair minus one
		opOperands = 3'd4,	// Present ALU operands
		opRst      = 3'd5,	// PC to restart vector
		opNop      = 3'd6
	} opE;

	typedef enum logic [2:0] {
		regA = 3'd0,
		regF = 3'd1,
		regB = 3'd2,
		regC = 3'd3,
		regD = 3'd4,
		regE = 3'd5,
		regH = 3'd6,
		regL = 3'd7
	} regSelE;

	typedef enum logic [1:0] {
		pairBC = 2'd0,
		pairDE = 2'd1,
		pairHL = 2'd2,
		pairSP = 2'd3
	} pairSelE;

	typedef enum logic [1:0] {
		stepNone = 2'd0,
		stepInc  = 2'd1,
		stepDec  = 2'd2
	} stepE;

	typedef struct packed {
		opE         op;
		regSelE     dst;
		regSelE     src;
		pairSelE    pair;
		logic [7:0] imm;	// Vector in [2:0] for rst, bc in [5:0] for operands
	} cmdT;

	typedef struct packed {
		logic       valid;		// One-cycle strobe
		logic       regWe;		// Register file write
		regSelE     dst;
		regSelE     src;
		logic       srcImm;		// Write data from imm, else from src
		logic [7:0] imm;
		stepE       pairStep;
		pairSelE    pair;
		logic       opndStb;	// Latch ALU operands
		logic [5:0] bc;			// Operand 2 mask control
		logic       rstStb;		// Restart load
		logic [2:0] vec;
	} ctrlT;

	typedef struct packed {
		logic [15:0] addr;	// External address bus
		logic [7:0]  aluOp1;
		logic [7:0]  aluOp2;
		logic        bq4;	// Decimal adjust hints
		logic        bq5;
		logic        bq7;
		logic [7:0]  regA;
	} resultT;

endpackage

`default_nettype wire

// File: rtl/cmdDecode.sv
`default_nettype none

module cmdDecode (
	input  logic                CLK,
	input  logic                arstN,
	input  logic                req,
	input  coreBottomPkg::cmdT  cmd,
	input  logic                busy,	// Handshake open in addrResult
	output coreBottomPkg::ctrlT ctrl
);

	coreBottomPkg::ctrlT ctrlNext;	// Decode of the command on the bus
	logic                capture;

	// Fresh req only when no transfer is open
	assign capture = req & ~busy;

	always_comb begin
		ctrlNext          = '0;
		ctrlNext.valid    = 1'b1;
		ctrlNext.dst      = cmd.dst;
		ctrlNext.src      = cmd.src;
		ctrlNext.pair     = cmd.pair;
		ctrlNext.imm      = cmd.imm;
		ctrlNext.pairStep = coreBottomPkg::stepNone;
		case (cmd.op)
			coreBottomPkg::opLoadImm: begin
				ctrlNext.regWe  = 1'b1;
				ctrlNext.srcImm = 1'b1;	// Data from imm
			end
			coreBottomPkg::opCopy: begin
				ctrlNext.regWe  = 1'b1;	// Data from src reg
			end
			coreBottomPkg::opIncPair: begin
				ctrlNext.pairStep = coreBottomPkg::stepInc;
			end
			coreBottomPkg::opDecPair: begin
				ctrlNext.pairStep = coreBottomPkg::stepDec;
			end
			coreBottomPkg::opOperands: begin
				ctrlNext.opndStb = 1'b1;
				ctrlNext.bc      = cmd.imm[5:0];
			end
			coreBottomPkg::opRst: begin
				ctrlNext.rstStb = 1'b1;
				ctrlNext.vec    = cmd.imm[2:0];	// Restart slot
			end
			default: begin
				ctrlNext.pairStep = coreBottomPkg::stepNone;	// Nop and unused codes
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ctrl <= '0;
		end else if (capture) begin
			ctrl <= ctrlNext;
		end else begin
			ctrl.valid <= 1'b0;	// Fields held, strobe dropped
		end
	end

	// busy from addrResult must close the window right after a capture
	aValidPulse: assert property (@(posedge CLK) disable iff (!arstN)
		ctrl.valid |=> !ctrl.valid);

endmodule

`default_nettype wire

// File: rtl/regExecute.sv
`default_nettype none

module regExecute #(
	parameter logic [coreBottomPkg::rstBaseW-1:0] RstBase = 16'h0000
) (
	input  logic                  CLK,
	input  logic                  arstN,
	input  coreBottomPkg::ctrlT   ctrl,
	input  logic [15:0]           pairWrite,	// Stepped pair from addrResult
	input  logic                  pairWe,
	output logic [15:0]           pairValue,
	output logic [1:0]            stepReq,
	output logic                  stepStrobe,	// Command executed
	output coreBottomPkg::resultT opnd
);

	logic [7:0][7:0]        regFile;	// A F B C D E H L
	logic [15:0]            sp;
	logic [15:0]            pc;
	coreBottomPkg::pairSelE pairSel;	// Held for the writeback
	logic                   rstDone;	// Last command loaded PC
	logic [15:0]            pairMux;
	logic [7:0]             aluOp1;
	logic [7:0]             aluOp2;
	logic [7:0]             regA;

	// Operand 2 masking, bc4 kills all, bc0 enables the high nibble bits
	function automatic logic [7:0] maskOp2(input logic [7:0] v, input logic [5:0] bc);
		logic [7:0] m;
		m = v;
		if (bc[4]) begin
			m = '0;
		end else if (bc[0]) begin
			m[4] = v[4] & ~bc[1];
			m[5] = v[5] & ~bc[5];
			m[6] = v[6] & ~bc[2];
			m[7] = v[7] & ~bc[3];
		end
		return m;
	endfunction

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regFile    <= '0;
			sp         <= '0;
			pc         <= RstBase;
			pairSel    <= coreBottomPkg::pairBC;
			rstDone    <= 1'b0;
			stepStrobe <= 1'b0;
			stepReq    <= '0;
			aluOp1     <= '0;
			aluOp2     <= '0;
		end else begin
			stepStrobe <= ctrl.valid;	// Hands off to addrResult
			if (ctrl.valid) begin
				pairSel <= ctrl.pair;
				rstDone <= ctrl.rstStb;
				stepReq <= ctrl.pairStep;
				if (ctrl.regWe) begin
					regFile[ctrl.dst] <= ctrl.srcImm ? ctrl.imm : regFile[ctrl.src];
				end
				if (ctrl.rstStb) begin
					pc <= RstBase + 16'({ctrl.vec, 3'b000});	// 8 bytes per slot
				end
				if (ctrl.opndStb) begin
					aluOp1 <= regFile[ctrl.src];
					aluOp2 <= maskOp2(regFile[ctrl.dst], ctrl.bc);
				end
			end
			if (pairWe) begin
				case (pairSel)
					coreBottomPkg::pairBC: begin
						regFile[coreBottomPkg::regB] <= pairWrite[15:8];
						regFile[coreBottomPkg::regC] <= pairWrite[7:0];
					end
					coreBottomPkg::pairDE: begin
						regFile[coreBottomPkg::regD] <= pairWrite[15:8];
						regFile[coreBottomPkg::regE] <= pairWrite[7:0];
					end
					coreBottomPkg::pairHL: begin
						regFile[coreBottomPkg::regH] <= pairWrite[15:8];
						regFile[coreBottomPkg::regL] <= pairWrite[7:0];
					end
					default: begin
						sp <= pairWrite;	// pairSP
					end
				endcase
			end
		end
	end

	always_comb begin
		case (pairSel)
			coreBottomPkg::pairBC: pairMux = {regFile[coreBottomPkg::regB], regFile[coreBottomPkg::regC]};
			coreBottomPkg::pairDE: pairMux = {regFile[coreBottomPkg::regD], regFile[coreBottomPkg::regE]};
			coreBottomPkg::pairHL: pairMux = {regFile[coreBottomPkg::regH], regFile[coreBottomPkg::regL]};
			default:               pairMux = sp;
		endcase
	end

	// After a restart the address bus shows the new PC
	assign pairValue = rstDone ? pc : pairMux;

	assign regA = regFile[coreBottomPkg::regA];

	always_comb begin
		opnd        = '0;	// addr comes from addrResult
		opnd.aluOp1 = aluOp1;
		opnd.aluOp2 = aluOp2;
		opnd.bq4    = |regA[3:1];
		opnd.bq5    = |regA[7:5];
		opnd.bq7    = regA[7] & regA[4];
		opnd.regA   = regA;
	end

	// Writeback from addrResult follows the execute strobe by one cycle
	aPairWeTiming: assert property (@(posedge CLK) disable iff (!arstN)
		pairWe |-> $past(stepStrobe));

endmodule

`default_nettype wire

// File: rtl/addrResult.sv
`default_nettype none

module addrResult (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic                  req,
	input  logic                  busDisable,
	input  logic [15:0]           pairValue,	// Old pair value
	input  logic [1:0]            stepReq,
	input  logic                  stepStrobe,
	input  coreBottomPkg::resultT opnd,
	output logic [15:0]           pairWrite,
	output logic                  pairWe,
	output logic                  ack,
	output logic                  busy,
	output coreBottomPkg::resultT result
);

	logic [15:0] addrQ;		// Address bus latch
	logic        inFlight;	// Capture until ack falls

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			addrQ    <= '0;
			pairWe   <= 1'b0;
			ack      <= 1'b0;
			inFlight <= 1'b0;
		end else begin
			// Same condition decode uses to capture
			if (!inFlight && req) begin
				inFlight <= 1'b1;
			end else if (ack && !req) begin
				inFlight <= 1'b0;
			end
			if (stepStrobe) begin
				addrQ <= busDisable ? 16'hFFFF : pairValue;	// Bus floats high
				ack   <= 1'b1;
			end else if (!req) begin
				ack   <= 1'b0;	// Four-phase return
			end
			pairWe <= stepStrobe && (stepReq != coreBottomPkg::stepNone);
		end
	end

	// Step still happens under bus disable, wraps mod 2^16
	always_ff @(posedge CLK) begin
		if (stepStrobe) begin
			if (stepReq == coreBottomPkg::stepDec) begin
				pairWrite <= pairValue - 16'd1;
			end else begin
				pairWrite <= pairValue + 16'd1;
			end
		end
	end

	assign busy = inFlight;

	always_comb begin
		result      = opnd;
		result.addr = addrQ;	// Operands and hints from execute
	end

	// Host keeps req up until it sees ack
	aAckNeedsReq: assert property (@(posedge CLK) disable iff (!arstN)
		$rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// File: rtl/coreBottom.sv
`default_nettype none

module coreBottom #(
	parameter logic [coreBottomPkg::rstBaseW-1:0] RstBase = 16'h0000
) (
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic                  req,
	input  coreBottomPkg::cmdT    cmd,
	input  logic                  busDisable,
	output logic                  ack,
	output coreBottomPkg::resultT result
);

	coreBottomPkg::ctrlT   ctrl;		// Decode to execute
	coreBottomPkg::resultT opnd;		// Operands and hints
	logic [15:0]           pairValue;
	logic [15:0]           pairWrite;
	logic [1:0]            stepReq;
	logic                  stepStrobe;
	logic                  pairWe;
	logic                  busy;

	cmdDecode i_cmdDecode (
		.CLK   (CLK),
		.arstN (arstN),
		.req   (req),
		.cmd   (cmd),
		.busy  (busy),
		.ctrl  (ctrl)
	);

	regExecute #(
		.RstBase (RstBase)
	) i_regExecute (
		.CLK        (CLK),
		.arstN      (arstN),
		.ctrl       (ctrl),
		.pairWrite  (pairWrite),
		.pairWe     (pairWe),
		.pairValue  (pairValue),
		.stepReq    (stepReq),
		.stepStrobe (stepStrobe),
		.opnd       (opnd)
	);

	addrResult i_addrResult (
		.CLK        (CLK),
		.arstN      (arstN),
		.req        (req),
		.busDisable (busDisable),
		.pairValue  (pairValue),
		.stepReq    (stepReq),
		.stepStrobe (stepStrobe),
		.opnd       (opnd),
		.pairWrite  (pairWrite),
		.pairWe     (pairWe),
		.ack        (ack),
		.busy       (busy),
		.result     (result)
	);

endmodule

`default_nettype wire

// File: bench/coreBottomVectors.svh
// Columns: op dst src pair imm, busDisable, then expected addr aluOp1 aluOp2 {bq4,bq5,bq7} A
// op 0 load 1 copy 2 inc 3 dec 4 operands 5 rst 6 nop; reg A F B C D E H L; pair BC DE HL SP

localparam int NumVecs = 28;

vecT vecTable [NumVecs];

task automatic loadVectors();
	vecTable[0]  = {3'd6,3'd0,3'd0,2'd0,8'h00, 1'b0, 16'h0000, 8'h00, 8'h00, 3'b000, 8'h00};	// Nop
	vecTable[1]  = {3'd0,3'd0,3'd0,2'd0,8'h3C, 1'b0, 16'h0000, 8'h00, 8'h00, 3'b110, 8'h3C};	// A
	vecTable[2]  = {3'd0,3'd2,3'd0,2'd0,8'h12, 1'b0, 16'h1200, 8'h00, 8'h00, 3'b110, 8'h3C};	// B
	vecTable[3]  = {3'd0,3'd3,3'd0,2'd0,8'hF5, 1'b0, 16'h12F5, 8'h00, 8'h00, 3'b110, 8'h3C};	// C
	vecTable[4]  = {3'd1,3'd4,3'd2,2'd1,8'h00, 1'b0, 16'h1200, 8'h00, 8'h00, 3'b110, 8'h3C};	// D from B
	vecTable[5]  = {3'd4,3'd3,3'd2,2'd1,8'h00, 1'b0, 16'h1200, 8'h12, 8'hF5, 3'b110, 8'h3C};	// No mask
	vecTable[6]  = {3'd4,3'd3,3'd0,2'd1,8'h10, 1'b0, 16'h1200, 8'h3C, 8'h00, 3'b110, 8'h3C};	// bc4 kill
	vecTable[7]  = {3'd4,3'd3,3'd0,2'd1,8'h0B, 1'b0, 16'h1200, 8'h3C, 8'h65, 3'b110, 8'h3C};	// Bits 4 7
	vecTable[8]  = {3'd4,3'd3,3'd2,2'd1,8'h0A, 1'b0, 16'h1200, 8'h12, 8'hF5, 3'b110, 8'h3C};	// bc0 off
	vecTable[9]  = {3'd0,3'd0,3'd0,2'd0,8'h90, 1'b0, 16'h12F5, 8'h12, 8'hF5, 3'b011, 8'h90};
	vecTable[10] = {3'd0,3'd0,3'd0,2'd0,8'h0E, 1'b0, 16'h12F5, 8'h12, 8'hF5, 3'b100, 8'h0E};
	vecTable[11] = {3'd0,3'd0,3'd0,2'd0,8'h00, 1'b0, 16'h12F5, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[12] = {3'd0,3'd2,3'd0,2'd0,8'hFF, 1'b0, 16'hFFF5, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[13] = {3'd0,3'd3,3'd0,2'd0,8'hFF, 1'b0, 16'hFFFF, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[14] = {3'd2,3'd0,3'd0,2'd0,8'h00, 1'b0, 16'hFFFF, 8'h12, 8'hF5, 3'b000, 8'h00};	// Wraps
	vecTable[15] = {3'd6,3'd0,3'd0,2'd0,8'h00, 1'b0, 16'h0000, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[16] = {3'd0,3'd6,3'd0,2'd2,8'h80, 1'b0, 16'h8000, 8'h12, 8'hF5, 3'b000, 8'h00};	// H
	vecTable[17] = {3'd0,3'd7,3'd0,2'd2,8'h10, 1'b0, 16'h8010, 8'h12, 8'hF5, 3'b000, 8'h00};	// L
	vecTable[18] = {3'd3,3'd0,3'd0,2'd2,8'h00, 1'b0, 16'h8010, 8'h12, 8'hF5, 3'b000, 8'h00};	// Old HL
	vecTable[19] = {3'd3,3'd0,3'd0,2'd2,8'h00, 1'b0, 16'h800F, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[20] = {3'd3,3'd0,3'd0,2'd2,8'h00, 1'b1, 16'hFFFF, 8'h12, 8'hF5, 3'b000, 8'h00};	// Disabled
	vecTable[21] = {3'd6,3'd0,3'd0,2'd2,8'h00, 1'b0, 16'h800D, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[22] = {3'd5,3'd0,3'd0,2'd2,8'h05, 1'b0, 16'h0128, 8'h12, 8'hF5, 3'b000, 8'h00};	// Rst 5
	vecTable[23] = {3'd2,3'd0,3'd0,2'd3,8'h00, 1'b0, 16'h0000, 8'h12, 8'hF5, 3'b000, 8'h00};	// SP up
	vecTable[24] = {3'd6,3'd0,3'd0,2'd3,8'h00, 1'b0, 16'h0001, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[25] = {3'd6,3'd0,3'd0,2'd2,8'h00, 1'b0, 16'h800D, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[26] = {3'd6,3'd0,3'd0,2'd0,8'h00, 1'b0, 16'h0000, 8'h12, 8'hF5, 3'b000, 8'h00};
	vecTable[27] = {3'd6,3'd0,3'd0,2'd1,8'h00, 1'b0, 16'h1200, 8'h12, 8'hF5, 3'b000, 8'h00};
endtask

// File: bench/coreBottomTb.sv
`default_nettype none

module coreBottomTb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		coreBottomPkg::cmdT cmd;
		logic               busDisable;
		logic [15:0]        addr;		// Expected from here on
		logic [7:0]         aluOp1;
		logic [7:0]         aluOp2;
		logic [2:0]         hints;		// bq4 bq5 bq7
		logic [7:0]         regA;
	} vecT;

	`include "coreBottomVectors.svh"

	localparam int CycleLimit = NumVecs * 10 + 50;	// Rows plus reset margin
	localparam int AckLatency = 3;					// Capture, execute, result

	logic                  CLK;
	logic                  arstN;
	logic                  req;
	coreBottomPkg::cmdT    cmd;
	logic                  busDisable;
	logic                  ack;
	coreBottomPkg::resultT result;
	int                    errors;
	int                    checks;
	int                    cycles;

	coreBottom #(
		.RstBase (16'h0100)
	) i_coreBottom (
		.CLK        (CLK),
		.arstN      (arstN),
		.req        (req),
		.cmd        (cmd),
		.busDisable (busDisable),
		.ack        (ack),
		.result     (result)
	);

	always #5 CLK = ~CLK;	// 10 ns period

	// Run limit
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Handshake timed out, no finish within %0d cycles", CycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic checkValue(input int row, input string field,
			input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t row %0d %s got %h expected %h", $time, row, field, got, exp);
		end
	endtask

	// Four-phase transfer of one table row
	task automatic applyRow(input int row);
		vecT v;
		int  waited;
		v          = vecTable[row];
		waited     = 0;
		cmd        = v.cmd;
		busDisable = v.busDisable;
		req        = 1'b1;
		while (!ack) begin
			@(posedge CLK);
			#1;
			waited++;
		end
		checkValue(row, "ack latency", 16'(waited), 16'(AckLatency));
		checkValue(row, "addr", result.addr, v.addr);
		checkValue(row, "aluOp1", result.aluOp1, v.aluOp1);
		checkValue(row, "aluOp2", result.aluOp2, v.aluOp2);
		checkValue(row, "bq4", result.bq4, v.hints[2]);
		checkValue(row, "bq5", result.bq5, v.hints[1]);
		checkValue(row, "bq7", result.bq7, v.hints[0]);
		checkValue(row, "regA", result.regA, v.regA);
		req = 1'b0;	// Return phase
		while (ack) begin
			@(posedge CLK);
			#1;
		end
		busDisable = 1'b0;
	endtask

	initial begin
		CLK        = 1'b0;
		arstN      = 1'b0;
		req        = 1'b0;
		cmd        = '0;
		busDisable = 1'b0;
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		loadVectors();
		repeat (2) @(posedge CLK);
		#1;
		arstN = 1'b1;
		@(posedge CLK);
		#1;
		checkValue(-1, "ack after reset", ack, 1'b0);	// Idle state
		checkValue(-1, "addr after reset", result.addr, 16'h0000);
		for (int i = 0; i < NumVecs; i++) begin
			applyRow(i);
		end
		$display("Checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/coreBottomPkg.sv
rtl/cmdDecode.sv
rtl/regExecute.sv
rtl/addrResult.sv
rtl/coreBottom.sv
+incdir+bench
bench/coreBottomTb.sv
